// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f vlog.f \
    -o sim_rv_core > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_rv_core > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu
(
    input  rv_pkg::alu_fun_t alu_fun,
    input  rv_pkg::word_t    a,
    input  rv_pkg::word_t    b,
    output rv_pkg::word_t    result
);

    logic [4:0] shamt;          // Shifts only use the low five bits of B
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb
    begin
        case (alu_fun)
            rv_pkg::ALU_ADD:      result = a + b;
            rv_pkg::ALU_SUB:      result = a - b;           // Wraps on underflow
            rv_pkg::ALU_SLL:      result = a << shamt;
            rv_pkg::ALU_SLT:      result = {31'd0, lt_signed};
            rv_pkg::ALU_SLTU:     result = {31'd0, lt_unsigned};
            rv_pkg::ALU_XOR:      result = a ^ b;
            rv_pkg::ALU_SRL:      result = a >> shamt;      // Zero fill
            rv_pkg::ALU_SRA:      result = $unsigned($signed(a) >>> shamt);  // Sign fill
            rv_pkg::ALU_OR:       result = a | b;
            rv_pkg::ALU_AND:      result = a & b;
            rv_pkg::ALU_LUI_COPY: result = b;
            default:              result = '0;
        endcase
    end

endmodule

// File: rv_apb_port.sv
`timescale 1ns/10ps

module rv_apb_port
(
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  rv_pkg::apb_addr_t paddr,
    input  rv_pkg::word_t     pwdata,
    output rv_pkg::word_t     prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              pipe_busy,    // Any stage valid bit set
    output logic              issue_valid,  // One-cycle pulse into ID
    output rv_pkg::word_t     issue_instr,
    output rv_pkg::reg_addr_t host_raddr,
    input  rv_pkg::word_t     host_rdata
);

    rv_pkg::apb_addr_t reg_off;     // Offset into register space
    logic              hit_issue;
    logic              hit_reg;     // Word-aligned, inside x0..x31
    logic              pending;     // Setup cycle, or access still waiting

    assign reg_off    = paddr - rv_pkg::REG_BASE;   // Below the base wraps out of range
    assign hit_issue  = (paddr == rv_pkg::ISSUE_ADDR);
    assign hit_reg    = (reg_off < 4 * rv_pkg::NUM_REGS) && (reg_off[1:0] == 2'b00);
    assign host_raddr = reg_off[6:2];
    assign pending    = psel && !pready;

    // The write completes on this edge, so ID loads on the same edge
    assign issue_valid = psel && penable && pready && pwrite && hit_issue;
    assign issue_instr = pwdata;

    ////////////////////////////////////////
    // Response, decided one cycle ahead
    ////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
        else
        begin
            pready  <= 1'b0;                // Single-cycle ready pulse
            pslverr <= 1'b0;
            if (pending)
            begin
                if (hit_reg && !pwrite)
                    pready <= !pipe_busy;   // Wait until the pipeline has drained
                else
                begin
                    pready  <= 1'b1;
                    pslverr <= !(hit_issue && pwrite);  // Bad address or direction
                end
            end
        end
    end

    // Read data captured together with the ready that returns it
    always_ff @(posedge CLK)
    begin
        if (pending && hit_reg && !pwrite && !pipe_busy)
            prdata <= host_rdata;
    end

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core
(
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  rv_pkg::apb_addr_t paddr,
    input  rv_pkg::word_t     pwdata,
    output rv_pkg::word_t     prdata,
    output logic              pready,
    output logic              pslverr
);

    // Host side
    logic              issue_valid;
    rv_pkg::word_t     issue_instr;
    rv_pkg::reg_addr_t host_raddr;
    rv_pkg::word_t     host_rdata;
    logic              pipe_busy;

    // ID stage
    logic              id_valid;
    rv_pkg::word_t     id_instr;

    // Decode outputs
    rv_pkg::reg_addr_t dec_rs1_addr, dec_rs2_addr;
    rv_pkg::word_t     dec_rs1_data, dec_rs2_data;
    rv_pkg::word_t     dec_a, dec_b;
    rv_pkg::alu_fun_t  dec_fun;
    rv_pkg::reg_addr_t dec_rd;
    logic              dec_write;

    // EX stage
    logic              ex_valid;
    rv_pkg::word_t     ex_a, ex_b;
    rv_pkg::alu_fun_t  ex_fun;
    rv_pkg::reg_addr_t ex_rd;
    logic              ex_write;
    rv_pkg::word_t     alu_result;

    // WB stage
    logic              wb_valid;
    rv_pkg::word_t     wb_result;
    rv_pkg::reg_addr_t wb_rd;
    logic              wb_write;
    logic              rf_we;

    assign pipe_busy = id_valid | ex_valid | wb_valid;
    assign rf_we     = wb_valid & wb_write;    // Stale payload never reaches the file

    rv_apb_port u_apb (.CLK(CLK), .rst_n(rst_n), .psel(psel), .penable(penable),
                       .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
                       .pready(pready), .pslverr(pslverr), .pipe_busy(pipe_busy),
                       .issue_valid(issue_valid), .issue_instr(issue_instr),
                       .host_raddr(host_raddr), .host_rdata(host_rdata));

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    rv_decoder u_dec (.instr(id_instr), .rs1_addr(dec_rs1_addr), .rs2_addr(dec_rs2_addr),
                      .rs1_data(dec_rs1_data), .rs2_data(dec_rs2_data), .op_a(dec_a),
                      .op_b(dec_b), .alu_fun(dec_fun), .rd_addr(dec_rd),
                      .rd_write(dec_write));

    // Bypass inside covers the WB-to-ID hazard
    rv_regfile u_rf (.CLK(CLK), .rs1_addr(dec_rs1_addr), .rs2_addr(dec_rs2_addr),
                     .host_raddr(host_raddr), .rs1_data(dec_rs1_data),
                     .rs2_data(dec_rs2_data), .host_rdata(host_rdata), .wr_addr(wb_rd),
                     .wr_data(wb_result), .wr_en(rf_we));

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    rv_alu u_alu (.alu_fun(ex_fun), .a(ex_a), .b(ex_b), .result(alu_result));

    ////////////////////////////////////////
    // Stage valid bits
    ////////////////////////////////////////

    // No stalls, so each bit just follows the one before it
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end
        else
        begin
            id_valid <= issue_valid;
            ex_valid <= id_valid;
            wb_valid <= ex_valid;
        end
    end

    // Pipeline payload
    always_ff @(posedge CLK)
    begin
        if (issue_valid)
            id_instr <= issue_instr;    // Held until the next issue
        ex_a      <= dec_a;
        ex_b      <= dec_b;
        ex_fun    <= dec_fun;
        ex_rd     <= dec_rd;
        ex_write  <= dec_write;
        wb_result <= alu_result;
        wb_rd     <= ex_rd;
        wb_write  <= ex_write;
    end

endmodule

// File: rv_core_assert.sv
`timescale 1ns/10ps

module rv_core_assert
(
    input logic              CLK,
    input logic              rst_n,
    input logic              psel,
    input logic              penable,
    input logic              pwrite,
    input rv_pkg::apb_addr_t paddr,
    input logic              pready,
    input logic              pslverr,
    input logic              pipe_busy      // OR of the stage valid bits
);

    logic reg_read;     // Read aimed at register space

    assign reg_read = psel && !pwrite && ((paddr - rv_pkg::REG_BASE) < 12'h080);

    // Error only rides on a completing transfer
    err_needs_ready: assert property (@(posedge CLK) disable iff (!rst_n)
        pslverr |-> pready) else $error("pslverr high without pready");

    // Issue never waits
    issue_no_wait: assert property (@(posedge CLK) disable iff (!rst_n)
        (psel && penable && !$past(penable) && pwrite && (paddr == rv_pkg::ISSUE_ADDR))
        |-> pready) else $error("Issue write did not complete in its first access cycle");

    read_after_drain: assert property (@(posedge CLK) disable iff (!rst_n)
        (reg_read && pready) |-> !pipe_busy) else $error("Register read ready while busy");

    valid_clear_after_reset: assert property (@(posedge CLK)
        !rst_n |=> !pipe_busy) else $error("Stage valid bit set after reset");

endmodule

bind rv_core rv_core_assert u_assert (.CLK(CLK), .rst_n(rst_n), .psel(psel),
    .penable(penable), .pwrite(pwrite), .paddr(paddr), .pready(pready),
    .pslverr(pslverr), .pipe_busy(pipe_busy));

// File: rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder
(
    input  rv_pkg::word_t     instr,        // Word held in the ID register
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,     // Register file, bypass included
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     op_a,         // ALU operand A for EX
    output rv_pkg::word_t     op_b,         // ALU operand B for EX
    output rv_pkg::alu_fun_t  alu_fun,
    output rv_pkg::reg_addr_t rd_addr,
    output logic              rd_write      // Result goes to the register file
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic            alt;       // funct7[5] where it really selects SUB or SRA
    rv_pkg::word_t   i_imm;     // Sign-extended I immediate
    rv_pkg::word_t   u_imm;     // Upper immediate, low 12 bits zero
    logic            rd_nz;

    ////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////

    assign opcode   = rv_pkg::opcode_t'(instr[6:0]);   // Unknown codes fall to default
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign rd_nz    = (instr[11:7] != 5'd0);    // Writes to x0 are dropped here

    // Bit 30 is part of the immediate for ADDI, so only shifts right and
    // the R-form ADD/SUB look at it
    assign alt = instr[30] &&
                 ((funct3 == 3'b101) || ((opcode == rv_pkg::OP) && (funct3 == 3'b000)));

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'h000};

    ////////////////////////////////////////
    // Control and operand select
    ////////////////////////////////////////

    always_comb
    begin
        op_a     = rs1_data;            // rs1 for both R and I forms
        op_b     = rs2_data;
        alu_fun  = rv_pkg::ALU_ADD;
        rd_write = 1'b0;
        case (opcode)
            rv_pkg::LUI:
            begin
                op_b     = u_imm;       // A is ignored by the copy
                alu_fun  = rv_pkg::ALU_LUI_COPY;
                rd_write = rd_nz;
            end
            rv_pkg::OP_IMM:
            begin
                op_b     = i_imm;       // Shift amount sits in the low five bits
                alu_fun  = rv_pkg::alu_fun_t'({alt, funct3});
                rd_write = rd_nz;
            end
            rv_pkg::OP:
            begin
                alu_fun  = rv_pkg::alu_fun_t'({alt, funct3});
                rd_write = rd_nz;
            end
            default:
                rd_write = 1'b0;        // NOP and unsupported opcodes retire silently
        endcase
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////

    typedef logic [31:0] word_t;        // Data word or instruction word
    typedef logic [4:0]  reg_addr_t;    // Architectural register index
    typedef logic [11:0] apb_addr_t;    // APB byte address

    localparam int NUM_REGS = 32;       // x0..x31, x0 reads as zero

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    // Only the register and immediate ALU forms survive here
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        NOP    = 7'b0000000     // All-zero word, retires with no effect
    } opcode_t;

    ////////////////////////////////////////
    // ALU functions
    ////////////////////////////////////////

    // Encoded as {funct7[5], funct3} so the decoder can build it from the
    // instruction fields directly
    typedef enum logic [3:0] {
        ALU_ADD      = 4'b0000,
        ALU_SUB      = 4'b1000,
        ALU_SLL      = 4'b0001,
        ALU_SLT      = 4'b0010,
        ALU_SLTU     = 4'b0011,
        ALU_XOR      = 4'b0100,
        ALU_SRL      = 4'b0101,
        ALU_SRA      = 4'b1101,
        ALU_OR       = 4'b0110,
        ALU_AND      = 4'b0111,
        ALU_LUI_COPY = 4'b1001      // Operand B passed straight through
    } alu_fun_t;

    ////////////////////////////////////////
    // APB address map
    ////////////////////////////////////////

    // Write only, one instruction per transfer
    localparam apb_addr_t ISSUE_ADDR = 12'h000;

    // Read only, REG_BASE + 4*n returns xn
    localparam apb_addr_t REG_BASE   = 12'h080;

endpackage

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile
(
    input  logic              CLK,
    input  rv_pkg::reg_addr_t rs1_addr,     // Decode read ports
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t host_raddr,   // APB read port
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     host_rdata,
    input  rv_pkg::reg_addr_t wr_addr,      // Writeback port
    input  rv_pkg::word_t     wr_data,
    input  logic              wr_en
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS] = '{default: '0};

    // One read port with x0 forced to zero and write-through from WB
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == 5'd0)
            return '0;
        else if (wr_en && (addr == wr_addr))
            return wr_data;                 // Same-cycle writeback wins
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        rs1_data   = read_port(rs1_addr);
        rs2_data   = read_port(rs2_addr);
        host_rdata = read_port(host_raddr);
    end

    always_ff @(posedge CLK)
    begin
        if (wr_en && (wr_addr != 5'd0))     // x0 never changes
            regs[wr_addr] <= wr_data;
    end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    typedef enum {ISSUE, CHECK, BAD_WRITE, BAD_READ} row_kind_t;

    localparam int HALF_PERIOD  = 10;       // 20 ns clock
    localparam int DRIVE_DELAY  = 2;        // Inputs move this long after the rising edge
    localparam int RESET_CYCLES = 8;

    logic              CLK;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    rv_pkg::apb_addr_t paddr;
    rv_pkg::word_t     pwdata;
    rv_pkg::word_t     prdata;
    logic              pready;
    logic              pslverr;

    // Stimulus table, one entry per row across the queues
    string         row_name [$];
    row_kind_t     row_kind [$];
    rv_pkg::word_t row_val  [$];    // Instruction, register index or APB address
    rv_pkg::word_t row_exp  [$];    // Expected register value for CHECK rows
    logic          row_err  [$];    // Expected pslverr

    int errors      = 0;
    int checks      = 0;
    bit table_ready = 1'b0;

    rv_core DUT (.CLK(CLK), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
                 .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
                 .pslverr(pslverr));

    initial
    begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic rv_pkg::word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                             input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_pkg::OP};
    endfunction

    function automatic rv_pkg::word_t u_type(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], rv_pkg::LUI};
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s pslverr: expected %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // APB master
    ////////////////////////////////////////

    // Starts and ends 2 ns after an edge, so back-to-back calls issue every second edge
    task automatic apb_transfer(input logic write, input rv_pkg::apb_addr_t addr,
                                input rv_pkg::word_t wdata, output rv_pkg::word_t rdata,
                                output logic err);
        psel    = 1'b1;             // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge CLK);
        #DRIVE_DELAY penable = 1'b1;
        while (!pready)             // Register reads stall until the pipeline drains
        begin
            @(posedge CLK);
            #DRIVE_DELAY;
        end
        rdata = prdata;             // Registered, steady up to the completing edge
        err   = pslverr;
        @(posedge CLK);
        #DRIVE_DELAY psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input rv_pkg::apb_addr_t addr, input rv_pkg::word_t data,
                             output logic err);
        rv_pkg::word_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input rv_pkg::apb_addr_t addr, output rv_pkg::word_t data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    task automatic add_row(input string name, input row_kind_t kind, input rv_pkg::word_t val,
                           input rv_pkg::word_t exp, input logic err);
        row_name.push_back(name);
        row_kind.push_back(kind);
        row_val.push_back(val);
        row_exp.push_back(exp);
        row_err.push_back(err);
    endtask

    task automatic build_table();
        add_row("x0 after reset", CHECK, 0, 32'h0, 1'b0);
        add_row("x1 after reset", CHECK, 1, 32'h0, 1'b0);
        add_row("x31 after reset", CHECK, 31, 32'h0, 1'b0);
        // Register-immediate forms and LUI
        add_row("addi x1", ISSUE, i_type(rv_pkg::OP_IMM, 3'b000, 1, 0, -5), 0, 1'b0);
        add_row("addi x2", ISSUE, i_type(rv_pkg::OP_IMM, 3'b000, 2, 1, -3), 0, 1'b0);
        add_row("slti x3", ISSUE, i_type(rv_pkg::OP_IMM, 3'b010, 3, 1, 1), 0, 1'b0);
        add_row("sltiu x4", ISSUE, i_type(rv_pkg::OP_IMM, 3'b011, 4, 1, 1), 0, 1'b0);
        add_row("xori x5", ISSUE, i_type(rv_pkg::OP_IMM, 3'b100, 5, 1, 'h0ff), 0, 1'b0);
        add_row("ori x6", ISSUE, i_type(rv_pkg::OP_IMM, 3'b110, 6, 0, 'h555), 0, 1'b0);
        add_row("andi x7", ISSUE, i_type(rv_pkg::OP_IMM, 3'b111, 7, 6, 'h0f0), 0, 1'b0);
        add_row("slli x8", ISSUE, i_type(rv_pkg::OP_IMM, 3'b001, 8, 6, 4), 0, 1'b0);
        add_row("srli x9", ISSUE, i_type(rv_pkg::OP_IMM, 3'b101, 9, 1, 28), 0, 1'b0);
        add_row("srai x10", ISSUE, i_type(rv_pkg::OP_IMM, 3'b101, 10, 1, 'h401), 0, 1'b0);
        add_row("lui x11", ISSUE, u_type(11, 20'h80000), 0, 1'b0);
        add_row("lui x12", ISSUE, u_type(12, 20'h12345), 0, 1'b0);
        add_row("addi x1 result", CHECK, 1, 32'hffff_fffb, 1'b0);     // -5
        add_row("addi x2 result", CHECK, 2, 32'hffff_fff8, 1'b0);     // -5 + -3
        add_row("slti x3 result", CHECK, 3, 32'h0000_0001, 1'b0);     // -5 < 1 signed
        add_row("sltiu x4 result", CHECK, 4, 32'h0000_0000, 1'b0);    // Huge unsigned
        add_row("xori x5 result", CHECK, 5, 32'hffff_ff04, 1'b0);
        add_row("ori x6 result", CHECK, 6, 32'h0000_0555, 1'b0);
        add_row("andi x7 result", CHECK, 7, 32'h0000_0050, 1'b0);
        add_row("slli x8 result", CHECK, 8, 32'h0000_5550, 1'b0);
        add_row("srli x9 result", CHECK, 9, 32'h0000_000f, 1'b0);     // Zero fill
        add_row("srai x10 result", CHECK, 10, 32'hffff_fffd, 1'b0);   // -3, sign fill
        add_row("lui x11 result", CHECK, 11, 32'h8000_0000, 1'b0);
        add_row("lui x12 result", CHECK, 12, 32'h1234_5000, 1'b0);
        // Register-register forms
        add_row("sub x13", ISSUE, r_type(7'h20, 3'b000, 13, 0, 6), 0, 1'b0);
        add_row("add x14", ISSUE, r_type(7'h00, 3'b000, 14, 11, 12), 0, 1'b0);
        add_row("sll x15", ISSUE, r_type(7'h00, 3'b001, 15, 6, 9), 0, 1'b0);
        add_row("slt x16", ISSUE, r_type(7'h00, 3'b010, 16, 11, 12), 0, 1'b0);
        add_row("sltu x17", ISSUE, r_type(7'h00, 3'b011, 17, 11, 12), 0, 1'b0);
        add_row("xor x18", ISSUE, r_type(7'h00, 3'b100, 18, 5, 1), 0, 1'b0);
        add_row("srl x19", ISSUE, r_type(7'h00, 3'b101, 19, 11, 8), 0, 1'b0);
        add_row("sra x20", ISSUE, r_type(7'h20, 3'b101, 20, 11, 8), 0, 1'b0);
        add_row("or x21", ISSUE, r_type(7'h00, 3'b110, 21, 6, 8), 0, 1'b0);
        add_row("and x22", ISSUE, r_type(7'h00, 3'b111, 22, 1, 2), 0, 1'b0);
        add_row("sub x13 result", CHECK, 13, 32'hffff_faab, 1'b0);    // 0 - 0x555 wraps
        add_row("add x14 result", CHECK, 14, 32'h9234_5000, 1'b0);
        add_row("sll x15 result", CHECK, 15, 32'h02aa_8000, 1'b0);    // Shift by 15
        add_row("slt x16 result", CHECK, 16, 32'h0000_0001, 1'b0);    // Negative < positive
        add_row("sltu x17 result", CHECK, 17, 32'h0000_0000, 1'b0);   // Same pair, unsigned
        add_row("xor x18 result", CHECK, 18, 32'h0000_00ff, 1'b0);
        add_row("srl x19 result", CHECK, 19, 32'h0000_8000, 1'b0);    // Shift by 16
        add_row("sra x20 result", CHECK, 20, 32'hffff_8000, 1'b0);
        add_row("or x21 result", CHECK, 21, 32'h0000_5555, 1'b0);
        add_row("and x22 result", CHECK, 22, 32'hffff_fff8, 1'b0);
        // Dependent chain, each result still in WB when the next one decodes
        add_row("chain addi x23", ISSUE, i_type(rv_pkg::OP_IMM, 3'b000, 23, 0, 7), 0, 1'b0);
        add_row("chain add x24", ISSUE, r_type(7'h00, 3'b000, 24, 23, 23), 0, 1'b0);
        add_row("chain sub x25", ISSUE, r_type(7'h20, 3'b000, 25, 24, 23), 0, 1'b0);
        add_row("chain xor x26", ISSUE, r_type(7'h00, 3'b100, 26, 24, 25), 0, 1'b0);
        add_row("chain x23 result", CHECK, 23, 32'h0000_0007, 1'b0);
        add_row("chain x24 result", CHECK, 24, 32'h0000_000e, 1'b0);
        add_row("chain x25 result", CHECK, 25, 32'h0000_0007, 1'b0);
        add_row("chain x26 result", CHECK, 26, 32'h0000_0009, 1'b0);  // rs2 through bypass
        // Retire with no effect
        add_row("addi x0", ISSUE, i_type(rv_pkg::OP_IMM, 3'b000, 0, 1, 100), 0, 1'b0);
        add_row("load opcode", ISSUE, i_type(7'b0000011, 3'b010, 1, 0, 0), 0, 1'b0);
        add_row("jalr opcode", ISSUE, i_type(7'b1100111, 3'b000, 2, 1, 0), 0, 1'b0);
        add_row("x0 after no-ops", CHECK, 0, 32'h0, 1'b0);
        add_row("x1 after no-ops", CHECK, 1, 32'hffff_fffb, 1'b0);
        add_row("x2 after no-ops", CHECK, 2, 32'hffff_fff8, 1'b0);
        // Bad accesses
        add_row("read of issue address", BAD_READ, 32'h000, 0, 1'b1);
        add_row("write into register space", BAD_WRITE, 32'h084, 0, 1'b1);
        add_row("unmapped read", BAD_READ, 32'h200, 0, 1'b1);
        add_row("unmapped write", BAD_WRITE, 32'h010, 0, 1'b1);
        add_row("x1 after bad accesses", CHECK, 1, 32'hffff_fffb, 1'b0);
    endtask

    task automatic run_row(input int i);
        rv_pkg::word_t     rdata;
        logic              err;
        rv_pkg::apb_addr_t addr;
        addr = rv_pkg::REG_BASE + {5'd0, row_val[i][4:0], 2'b00};    // xn at base + 4n
        case (row_kind[i])
            ISSUE:
                apb_write(rv_pkg::ISSUE_ADDR, row_val[i], err);
            CHECK:
            begin
                apb_read(addr, rdata, err);
                check_word(row_name[i], row_exp[i], rdata);
            end
            BAD_WRITE:      // Would set x1 to 1 if it were taken as an issue
                apb_write(row_val[i][11:0], i_type(rv_pkg::OP_IMM, 3'b000, 1, 0, 1), err);
            default:
                apb_read(row_val[i][11:0], rdata, err);
        endcase
        check_err(row_name[i], row_err[i], err);
    endtask

    ////////////////////////////////////////
    // Watchdog and main sequence
    ////////////////////////////////////////

    initial
    begin
        int limit;
        wait (table_ready);
        limit = row_name.size() * 40 + 200;     // Generous per-row budget
        repeat (limit) @(posedge CLK);
        errors++;
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY rst_n = 1'b1;
        foreach (row_name[i])
            run_row(i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_apb_port.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv
